/* run.sh */
#!/bin/sh
# builds the EX1 testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module ex1StageTb -f sources.f
./obj_dir/Vex1StageTb | tee sim.log

if grep -q "No errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* sources.f */
src/ex1Pkg.sv
src/opQualify.sv
src/addressGen.sv
src/execDispatch.sv
src/redirectMerge.sv
src/ex1Stage.sv
test/clockGen.sv
test/ex1Stage_chk.sv
test/ex1StageTb.sv

/* src/addressGen.sv */
// base plus scaled index, scale from ixt[5:4]
// address mode follows SR.JQ one cycle late, reset starts in 32-bit mode
`timescale 1ns/1ps
`default_nettype none

module addressGen (
	input logic clock,
	input logic reset,
	input ex1Pkg::gpr_t baseVal,
	input ex1Pkg::gpr_t indexVal,
	input ex1Pkg::ixt_t opUIxt,
	input logic srJqIn,
	output ex1Pkg::vaddr_t aguAddr
);
	import ex1Pkg::*;

	logic jqMode;
	logic [1:0] scale;
	vaddr_t sum48;
	logic [31:0] sum32;

	// registered copy of SR.JQ
	always_ff @(posedge clock) begin
		if (reset)
			jqMode <= 1'b0;
		else
			jqMode <= srJqIn;
	end

	assign scale = opUIxt[5:4];

	// both widths computed, mode picks one
	assign sum48 = baseVal[47:0] + (indexVal[47:0] << scale);
	assign sum32 = baseVal[31:0] + (indexVal[31:0] << scale);

	// 32-bit mode leaves the upper 16 bits clear
	assign aguAddr = jqMode ? sum48 : {16'h0000, sum32};

endmodule

`default_nettype wire

/* src/ex1Pkg.sv */
// shared widths, command encodings and constants of the EX1 stage
// the widths are architectural and not meant to be changed
`default_nettype none

package ex1Pkg;

	// architectural widths
	typedef logic [63:0] gpr_t;
	typedef logic [47:0] vaddr_t;
	typedef logic [5:0] regId_t;
	typedef logic [4:0] crId_t;
	// immediate with its sign bit on top
	typedef logic [32:0] imm_t;
	typedef logic [7:0] ixt_t;
	typedef logic [15:0] trap_t;
	typedef logic [4:0] memOpm_t;
	typedef logic [1:0] memOk_t;

	// main opcode field, opUCmd[5:0]
	typedef enum logic [5:0] {
		nop = 6'h00,
		invOp = 6'h01,
		leaMr = 6'h02,
		movRm = 6'h03,
		movMr = 6'h04,
		alu3 = 6'h05,
		unary = 6'h06,
		aluw3 = 6'h07,
		mul3 = 6'h08,
		mulw3 = 6'h09,
		movRc = 6'h0A,
		movCr = 6'h0B,
		movIr = 6'h0C,
		bra = 6'h0D,
		braNb = 6'h0E,
		bsr = 6'h0F,
		jmp = 6'h10,
		jsr = 6'h11,
		opIxs = 6'h12,
		opIxt = 6'h13
	} ucmd_t;

	// condition field, opUCmd[7:6]
	typedef enum logic [1:0] {
		condAlways = 2'b00,
		condNever = 2'b01,
		condTrue = 2'b10,
		condFalse = 2'b11
	} cond_t;

	// sub-ops carried in opUIxt[5:0]
	typedef enum logic [5:0] {
		ixsNop = 6'h00,
		ixsMovt = 6'h01,
		ixsMovnt = 6'h02,
		ixsTrapb = 6'h03
	} ixsOp_t;

	typedef enum logic [5:0] {
		ixtNop = 6'h00,
		ixtSleep = 6'h01,
		ixtBreak = 6'h02,
		ixtClrt = 6'h03,
		ixtSett = 6'h04,
		ixtClrs = 6'h05,
		ixtSets = 6'h06,
		ixtNott = 6'h07,
		ixtNots = 6'h08,
		ixtRte = 6'h09,
		ixtTrapa = 6'h0A,
		ixtSyse = 6'h0B
	} ixtOp_t;

	// memory op modes, load/store are prefix + unsigned bit + size
	localparam memOpm_t memOpmReady = 5'b00000;
	localparam memOpm_t memOpmTrap = 5'b00111;
	localparam logic [1:0] memPfxStore = 2'b10;
	localparam logic [1:0] memPfxLoad = 2'b01;
	localparam memOk_t memOkHold = 2'd1;

	// register ids
	localparam regId_t grZero = 6'h00;
	localparam crId_t crZero = 5'h00;
	localparam crId_t crPc = 5'h01;

	// trap codes
	localparam trap_t trapRte = 16'hFF00;
	localparam logic [11:0] trapaPrefix = 12'hC08;
	localparam logic [3:0] syscallNibble = 4'hE;

	// SR bit positions
	localparam int srT = 0;
	localparam int srS = 1;
	localparam int srJq = 31;

endpackage

`default_nettype wire

/* src/ex1Stage.sv */
// EX1 stage top, wiring only
// opUCmd[7:6] is the condition, [5:0] the opcode; inputs hold while exHold is up
`timescale 1ns/1ps
`default_nettype none

module ex1Stage (
	input logic clock,
	input logic reset,
	input logic [7:0] opUCmd,
	input ex1Pkg::ixt_t opUIxt,
	input logic opBraFlush,
	input logic opPreBra,
	input ex1Pkg::regId_t regIdRm,
	input ex1Pkg::gpr_t regValRs,
	input ex1Pkg::gpr_t regValRt,
	input ex1Pkg::gpr_t regValRm,
	input ex1Pkg::gpr_t regValCRm,
	input ex1Pkg::vaddr_t regValPc,
	input ex1Pkg::imm_t regValImm,
	input ex1Pkg::gpr_t regInSr,
	input ex1Pkg::vaddr_t regInLr,
	input ex1Pkg::gpr_t regInDlr,
	input ex1Pkg::gpr_t regInExc,
	input ex1Pkg::memOk_t memDataOK,
	output ex1Pkg::regId_t regIdRn1,
	output ex1Pkg::gpr_t regValRn1,
	output ex1Pkg::regId_t heldIdRn1,
	output ex1Pkg::crId_t regIdCn1,
	output ex1Pkg::gpr_t regValCn1,
	output logic exHold,
	output logic regHeld,
	output ex1Pkg::trap_t exTrapExc,
	output ex1Pkg::vaddr_t memAddr,
	output ex1Pkg::memOpm_t memOpm,
	output ex1Pkg::gpr_t memDataOut,
	output ex1Pkg::gpr_t regOutSr,
	output ex1Pkg::vaddr_t regOutLr
);
	import ex1Pkg::*;

	ucmd_t effCmd;
	vaddr_t aguAddr;
	crId_t crId;
	gpr_t crVal;
	logic doBranch;
	vaddr_t branchTarget;
	logic faultHold;
	logic memRequest;

	// condition check against SR.T
	opQualify uQualify (
		.opUCmd(opUCmd),
		.opBraFlush(opBraFlush),
		.srTIn(regInSr[srT]),
		.effCmd(effCmd)
	);

	// Rs is the base, Rt the index
	addressGen uAgu (
		.clock(clock),
		.reset(reset),
		.baseVal(regValRs),
		.indexVal(regValRt),
		.opUIxt(opUIxt),
		.srJqIn(regInSr[srJq]),
		.aguAddr(aguAddr)
	);

	execDispatch uDispatch (
		.effCmd(effCmd),
		.opUIxt(opUIxt),
		.opPreBra(opPreBra),
		.aguAddr(aguAddr),
		.regIdRm(regIdRm),
		.regValRs(regValRs),
		.regValRt(regValRt),
		.regValRm(regValRm),
		.regValCRm(regValCRm),
		.regInSr(regInSr),
		.regInDlr(regInDlr),
		.regValPc(regValPc),
		.regInLr(regInLr),
		.regValImm(regValImm),
		.regInExc(regInExc),
		.gprId(regIdRn1),
		.gprVal(regValRn1),
		.crId(crId),
		.crVal(crVal),
		.heldId(heldIdRn1),
		.doBranch(doBranch),
		.branchTarget(branchTarget),
		.faultHold(faultHold),
		.memRequest(memRequest),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.memDataOut(memDataOut),
		.regOutSr(regOutSr),
		.regOutLr(regOutLr),
		.exTrapExc(exTrapExc)
	);

	redirectMerge uMerge (
		.crId(crId),
		.crVal(crVal),
		.doBranch(doBranch),
		.branchTarget(branchTarget),
		.heldId(heldIdRn1),
		.faultHold(faultHold),
		.memRequest(memRequest),
		.memDataOK(memDataOK),
		.regIdCn1(regIdCn1),
		.regValCn1(regValCn1),
		.exHold(exHold),
		.regHeld(regHeld)
	);

endmodule

`default_nettype wire

/* src/execDispatch.sv */
// decodes the qualified command into writes, memory start, SR and trap updates
// memory ops are only started here and their completion and data return happen later
// branch redirect is resolved by the merge stage
`timescale 1ns/1ps
`default_nettype none

module execDispatch (
	input ex1Pkg::ucmd_t effCmd,
	input ex1Pkg::ixt_t opUIxt,
	input logic opPreBra,
	input ex1Pkg::vaddr_t aguAddr,
	input ex1Pkg::regId_t regIdRm,
	input ex1Pkg::gpr_t regValRs,
	input ex1Pkg::gpr_t regValRt,
	input ex1Pkg::gpr_t regValRm,
	input ex1Pkg::gpr_t regValCRm,
	input ex1Pkg::gpr_t regInSr,
	input ex1Pkg::gpr_t regInDlr,
	input ex1Pkg::vaddr_t regValPc,
	input ex1Pkg::vaddr_t regInLr,
	input ex1Pkg::imm_t regValImm,
	input ex1Pkg::gpr_t regInExc,
	output ex1Pkg::regId_t gprId,
	output ex1Pkg::gpr_t gprVal,
	output ex1Pkg::crId_t crId,
	output ex1Pkg::gpr_t crVal,
	output ex1Pkg::regId_t heldId,
	output logic doBranch,
	output ex1Pkg::vaddr_t branchTarget,
	output logic faultHold,
	output logic memRequest,
	output ex1Pkg::vaddr_t memAddr,
	output ex1Pkg::memOpm_t memOpm,
	output ex1Pkg::gpr_t memDataOut,
	output ex1Pkg::gpr_t regOutSr,
	output ex1Pkg::vaddr_t regOutLr,
	output ex1Pkg::trap_t exTrapExc
);
	import ex1Pkg::*;

	vaddr_t relTarget;
	logic [2:0] sizeBits;

	// pc-relative target keeps the pc's upper segment
	assign relTarget = {regValPc[47:32], aguAddr[31:0]};
	// unsigned bit and size with the prefix added per op
	assign sizeBits = {opUIxt[2], opUIxt[5:4]};

	// memOpm qualifies the address and store data that always go out
	assign memAddr = aguAddr;
	assign memDataOut = regValRm;

	always_comb begin
		gprId = grZero;
		gprVal = '0;
		crId = crZero;
		crVal = '0;
		heldId = grZero;
		doBranch = 1'b0;
		branchTarget = relTarget;
		faultHold = 1'b0;
		memRequest = 1'b0;
		memOpm = memOpmReady;
		regOutSr = regInSr;
		regOutLr = regInLr;
		exTrapExc = '0;

		case (effCmd)
			nop: begin
			end
			leaMr: begin
				gprId = regIdRm;
				gprVal = {16'h0000, aguAddr};
			end
			movRm: begin
				memRequest = 1'b1;
				memOpm = {memPfxStore, sizeBits};
			end
			movMr: begin
				memRequest = 1'b1;
				memOpm = {memPfxLoad, sizeBits};
				// loaded value arrives in a later stage
				heldId = regIdRm;
			end
			// results come from later stages
			alu3, unary, aluw3, mul3, mulw3: heldId = regIdRm;
			movRc: begin
				crId = regIdRm[4:0];
				crVal = regValRs;
			end
			movCr: begin
				gprId = regIdRm;
				gprVal = regValCRm;
			end
			movIr: begin
				gprId = regIdRm;
				case (opUIxt[3:0])
					// plain sign-extended immediate
					4'h0: gprVal = {{31{regValImm[32]}}, regValImm};
					// shift-and-insert forms
					4'h1: gprVal = {regValRs[55:0], regValImm[7:0]};
					4'h2: gprVal = {regValRs[47:0], regValImm[15:0]};
					4'h3: gprVal = {regValRs[31:0], regValImm[31:0]};
					// jumbo form with the value prebuilt in Rt
					default: gprVal = regValRt;
				endcase
			end
			braNb: begin
				// predicted taken but not taken so fall back to pc
				if (opPreBra) begin
					doBranch = 1'b1;
					branchTarget = regValPc;
				end
			end
			// predicted branches were already redirected in fetch
			bra: doBranch = !opPreBra;
			bsr: begin
				regOutLr = regValPc;
				doBranch = !opPreBra;
			end
			jmp: begin
				doBranch = 1'b1;
				branchTarget = regValRs[47:0];
			end
			jsr: begin
				regOutLr = regValPc;
				doBranch = 1'b1;
				branchTarget = regValRs[47:0];
			end
			opIxs: begin
				case (ixsOp_t'(opUIxt[5:0]))
					ixsNop: begin
					end
					ixsMovt: begin
						gprId = regIdRm;
						gprVal = {63'h0, regInSr[srT]};
					end
					ixsMovnt: begin
						gprId = regIdRm;
						gprVal = {63'h0, !regInSr[srT]};
					end
					ixsTrapb: begin
						memRequest = 1'b1;
						memOpm = memOpmTrap;
					end
					default: faultHold = 1'b1;
				endcase
			end
			opIxt: begin
				case (ixtOp_t'(opUIxt[5:0]))
					ixtNop, ixtSleep: begin
					end
					// debugger may let a break through
					ixtBreak: faultHold = !regInExc[15];
					ixtClrt: regOutSr[srT] = 1'b0;
					ixtSett: regOutSr[srT] = 1'b1;
					ixtClrs: regOutSr[srS] = 1'b0;
					ixtSets: regOutSr[srS] = 1'b1;
					ixtNott: regOutSr[srT] = !regInSr[srT];
					ixtNots: regOutSr[srS] = !regInSr[srS];
					ixtRte: exTrapExc = trapRte;
					ixtTrapa: exTrapExc = {trapaPrefix, regIdRm[3:0]};
					// syscall number from DLR
					ixtSyse: exTrapExc = {syscallNibble, regInDlr[11:0]};
					default: faultHold = 1'b1;
				endcase
			end
			// invOp and every unknown opcode stall the pipe
			default: faultHold = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

/* src/opQualify.sv */
// condition and flush gating of the incoming micro-command
// a disabled bra still reaches dispatch as braNb unless flushed
`timescale 1ns/1ps
`default_nettype none

module opQualify (
	input logic [7:0] opUCmd,
	input logic opBraFlush,
	input logic srTIn,
	output ex1Pkg::ucmd_t effCmd
);
	import ex1Pkg::*;

	cond_t cond;
	ucmd_t rawCmd;
	logic opEnable;

	// split the command byte
	assign cond = cond_t'(opUCmd[7:6]);
	assign rawCmd = ucmd_t'(opUCmd[5:0]);

	always_comb begin
		case (cond)
			condAlways: opEnable = 1'b1;
			condNever: opEnable = 1'b0;
			condTrue: opEnable = srTIn;
			default: opEnable = !srTIn;
		endcase
		// flush wins over any condition
		if (opBraFlush)
			opEnable = 1'b0;
	end

	// squashed bra still needs the not-taken path
	always_comb begin
		if (opEnable)
			effCmd = rawCmd;
		else if ((rawCmd == bra) && !opBraFlush)
			effCmd = braNb;
		else
			effCmd = nop;
	end

endmodule

`default_nettype wire

/* src/redirectMerge.sv */
// branch redirect overrides any ordinary control register write
// exHold covers decode faults and a memory port reporting hold
`timescale 1ns/1ps
`default_nettype none

module redirectMerge (
	input ex1Pkg::crId_t crId,
	input ex1Pkg::gpr_t crVal,
	input logic doBranch,
	input ex1Pkg::vaddr_t branchTarget,
	input ex1Pkg::regId_t heldId,
	input logic faultHold,
	input logic memRequest,
	input ex1Pkg::memOk_t memDataOK,
	output ex1Pkg::crId_t regIdCn1,
	output ex1Pkg::gpr_t regValCn1,
	output logic exHold,
	output logic regHeld
);
	import ex1Pkg::*;

	logic memStall;

	// redirect goes out as a PC write
	assign regIdCn1 = doBranch ? crPc : crId;
	assign regValCn1 = doBranch ? {16'h0000, branchTarget} : crVal;

	// only a started memory op waits on the port
	assign memStall = memRequest && (memDataOK == memOkHold);
	assign exHold = faultHold || memStall;

	// any pending destination marks the stage as holding a result
	assign regHeld = (heldId != grZero);

endmodule

`default_nettype wire

/* test/clockGen.sv */
// free-running 8 ns clock and a synchronous reset held for 8 cycles
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clock,
	output logic reset
);
	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// release on a rising edge so the design sees a clean deassert
	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* test/ex1StageTb.sv */
// directed tests for the EX1 stage whose outputs are combinational except the address mode
// inputs change on the rising edge and outputs are sampled on the falling edge
`timescale 1ns/1ps
`default_nettype none

module ex1StageTb;
	import ex1Pkg::*;

	localparam int resetTimeout = 100;
	localparam int holdTimeout = 20;

	logic clock;
	logic reset;
	logic [7:0] opUCmd;
	ixt_t opUIxt;
	logic opBraFlush;
	logic opPreBra;
	regId_t regIdRm;
	gpr_t regValRs;
	gpr_t regValRt;
	gpr_t regValRm;
	gpr_t regValCRm;
	vaddr_t regValPc;
	imm_t regValImm;
	gpr_t regInSr;
	vaddr_t regInLr;
	gpr_t regInDlr;
	gpr_t regInExc;
	memOk_t memDataOK;
	regId_t regIdRn1;
	gpr_t regValRn1;
	regId_t heldIdRn1;
	crId_t regIdCn1;
	gpr_t regValCn1;
	logic exHold;
	logic regHeld;
	trap_t exTrapExc;
	vaddr_t memAddr;
	memOpm_t memOpm;
	gpr_t memDataOut;
	gpr_t regOutSr;
	vaddr_t regOutLr;

	int errors;
	ucmd_t branchCmds [4] = '{bra, bsr, jmp, jsr};
	ucmd_t longCmds [5] = '{alu3, unary, aluw3, mul3, mulw3};
	ixtOp_t srOps [6] = '{ixtClrt, ixtSett, ixtClrs, ixtSets, ixtNott, ixtNots};

	clockGen uClock (
		.clock(clock),
		.reset(reset)
	);

	ex1Stage DUT (
		.clock(clock),
		.reset(reset),
		.opUCmd(opUCmd),
		.opUIxt(opUIxt),
		.opBraFlush(opBraFlush),
		.opPreBra(opPreBra),
		.regIdRm(regIdRm),
		.regValRs(regValRs),
		.regValRt(regValRt),
		.regValRm(regValRm),
		.regValCRm(regValCRm),
		.regValPc(regValPc),
		.regValImm(regValImm),
		.regInSr(regInSr),
		.regInLr(regInLr),
		.regInDlr(regInDlr),
		.regInExc(regInExc),
		.memDataOK(memDataOK),
		.regIdRn1(regIdRn1),
		.regValRn1(regValRn1),
		.heldIdRn1(heldIdRn1),
		.regIdCn1(regIdCn1),
		.regValCn1(regValCn1),
		.exHold(exHold),
		.regHeld(regHeld),
		.exTrapExc(exTrapExc),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.memDataOut(memDataOut),
		.regOutSr(regOutSr),
		.regOutLr(regOutLr)
	);

	// one compare task per result type
	task automatic checkGpr(input string name, input gpr_t expVal, input gpr_t actVal);
		if (actVal !== expVal) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, expVal, actVal);
		end
	endtask

	task automatic checkAddr(input string name, input vaddr_t expVal, input vaddr_t actVal);
		if (actVal !== expVal) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, expVal, actVal);
		end
	endtask

	task automatic checkRegId(input string name, input regId_t expVal, input regId_t actVal);
		if (actVal !== expVal) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, expVal, actVal);
		end
	endtask

	task automatic checkCrId(input string name, input crId_t expVal, input crId_t actVal);
		if (actVal !== expVal) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, expVal, actVal);
		end
	endtask

	task automatic checkTrap(input string name, input trap_t expVal, input trap_t actVal);
		if (actVal !== expVal) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, expVal, actVal);
		end
	endtask

	task automatic checkOpm(input string name, input memOpm_t expVal, input memOpm_t actVal);
		if (actVal !== expVal) begin
			errors++;
			$display("error %s: expected %b, actual %b", name, expVal, actVal);
		end
	endtask

	task automatic checkBit(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal) begin
			errors++;
			$display("error %s: expected %b, actual %b", name, expVal, actVal);
		end
	endtask

	function automatic gpr_t randGpr();
		return {$urandom, $urandom};
	endfunction

	// enable rule of the condition field
	function automatic logic condEnabled(input cond_t cond, input logic t);
		return (cond == condAlways) || ((cond == condTrue) && t) || ((cond == condFalse) && !t);
	endfunction

	// time-zero values give a nop under condAlways
	task automatic initInputs();
		opUCmd = 8'h00;
		opUIxt = 8'h00;
		opBraFlush = 1'b0;
		opPreBra = 1'b0;
		regIdRm = grZero;
		regValRs = '0;
		regValRt = '0;
		regValRm = '0;
		regValCRm = '0;
		regValPc = '0;
		regValImm = '0;
		regInSr = '0;
		regInLr = '0;
		regInDlr = '0;
		regInExc = '0;
		memDataOK = 2'd0;
	endtask

	task automatic waitResetRelease();
		int count;
		count = 0;
		while (reset && (count < resetTimeout)) begin
			@(posedge clock);
			count++;
		end
		if (reset) begin
			errors++;
			$display("timeout: reset was never released");
		end
		@(negedge clock);
	endtask

	task automatic conditionGating();
		gpr_t r;
		gpr_t expVal;
		imm_t imm;
		for (int c = 0; c < 4; c++) begin
			for (int t = 0; t < 2; t++) begin
				r = randGpr();
				imm = r[32:0];
				// cover both immediate signs
				imm[32] = c[0] ^ t[0];
				// upper bits copy the immediate's sign
				expVal = imm[32] ? {31'h7FFF_FFFF, imm} : {31'h0, imm};
				@(posedge clock);
				regInSr <= {63'h0, t[0]};
				opUCmd <= {c[1:0], movIr};
				opUIxt <= 8'h00;
				regIdRm <= 6'h05;
				regValImm <= imm;
				@(negedge clock);
				if (condEnabled(cond_t'(c[1:0]), t[0])) begin
					checkRegId($sformatf("gate id c%0d t%0d", c, t), 6'h05, regIdRn1);
					checkGpr($sformatf("gate value c%0d t%0d", c, t), expVal, regValRn1);
				end else
					checkRegId($sformatf("gate off c%0d t%0d", c, t), grZero, regIdRn1);
			end
		end
		// flush beats condAlways and leaves every output idle
		@(posedge clock);
		opBraFlush <= 1'b1;
		opUCmd <= {condAlways, movIr};
		@(negedge clock);
		checkRegId("flush gpr id", grZero, regIdRn1);
		checkRegId("flush held id", grZero, heldIdRn1);
		checkCrId("flush cr id", crZero, regIdCn1);
		checkOpm("flush opm", memOpmReady, memOpm);
		checkTrap("flush trap", 16'h0000, exTrapExc);
		checkBit("flush hold", 1'b0, exHold);
		checkBit("flush held", 1'b0, regHeld);
		@(posedge clock);
		opBraFlush <= 1'b0;
	endtask

	task automatic addressAndMemory();
		gpr_t base;
		gpr_t index;
		gpr_t data;
		vaddr_t expAddr;
		logic [31:0] low;
		logic u;
		for (int m = 1; m >= 0; m--) begin
			// mode flag picks up SR.JQ at the following edge
			@(posedge clock);
			regInSr <= m[0] ? 64'h8000_0000 : 64'h0;
			opUCmd <= {condAlways, nop};
			for (int s = 0; s < 4; s++) begin
				base = randGpr();
				index = randGpr();
				data = randGpr();
				u = s[1] ^ m[0];
				if (m[0])
					expAddr = base[47:0] + index[47:0] * (48'd1 << s);
				else begin
					low = base[31:0] + index[31:0] * (32'd1 << s);
					expAddr = {16'h0000, low};
				end
				@(posedge clock);
				regValRs <= base;
				regValRt <= index;
				regValRm <= data;
				regIdRm <= 6'h09;
				memDataOK <= 2'd0;
				opUIxt <= {2'b00, s[1:0], 1'b0, u, 2'b00};
				opUCmd <= {condAlways, movRm};
				@(negedge clock);
				checkAddr($sformatf("store addr m%0d s%0d", m, s), expAddr, memAddr);
				checkOpm($sformatf("store opm m%0d s%0d", m, s), {2'b10, u, s[1:0]}, memOpm);
				checkGpr($sformatf("store data m%0d s%0d", m, s), data, memDataOut);
				checkRegId($sformatf("store held m%0d s%0d", m, s), grZero, heldIdRn1);
				@(posedge clock);
				opUCmd <= {condAlways, movMr};
				@(negedge clock);
				checkAddr($sformatf("load addr m%0d s%0d", m, s), expAddr, memAddr);
				checkOpm($sformatf("load opm m%0d s%0d", m, s), {2'b01, u, s[1:0]}, memOpm);
				checkRegId($sformatf("load held m%0d s%0d", m, s), 6'h09, heldIdRn1);
				checkBit($sformatf("load flag m%0d s%0d", m, s), 1'b1, regHeld);
				@(posedge clock);
				regIdRm <= 6'h07;
				opUCmd <= {condAlways, leaMr};
				@(negedge clock);
				checkRegId($sformatf("lea id m%0d s%0d", m, s), 6'h07, regIdRn1);
				checkGpr($sformatf("lea value m%0d s%0d", m, s), {16'h0000, expAddr}, regValRn1);
			end
		end
		@(posedge clock);
		opUIxt <= {2'b00, ixsTrapb};
		opUCmd <= {condAlways, opIxs};
		@(negedge clock);
		checkOpm("trapb opm", memOpmTrap, memOpm);
	endtask

	task automatic branchRedirect();
		gpr_t r;
		gpr_t rs;
		gpr_t rt;
		vaddr_t pc;
		vaddr_t lrIn;
		vaddr_t target;
		logic taken;
		logic call;
		ucmd_t cmd;
		cond_t cond;
		r = randGpr();
		pc = r[47:0];
		r = randGpr();
		lrIn = r[47:0];
		rs = randGpr();
		rt = randGpr();
		// index 4 is the squashed bra
		for (int i = 0; i < 5; i++) begin
			for (int p = 0; p < 2; p++) begin
				cmd = (i < 4) ? branchCmds[i] : bra;
				cond = (i < 4) ? condAlways : condNever;
				call = (cmd == bsr) || (cmd == jsr);
				if (i == 4) begin
					taken = p[0];
					target = pc;
				end else if ((cmd == jmp) || (cmd == jsr)) begin
					taken = 1'b1;
					target = rs[47:0];
				end else begin
					taken = !p[0];
					target = {pc[47:32], rs[31:0] + rt[31:0]};
				end
				@(posedge clock);
				regValPc <= pc;
				regInLr <= lrIn;
				regValRs <= rs;
				regValRt <= rt;
				opUIxt <= 8'h00;
				opPreBra <= p[0];
				opUCmd <= {cond, cmd};
				@(negedge clock);
				if (taken) begin
					checkCrId($sformatf("branch id %0d pre%0d", i, p), crPc, regIdCn1);
					checkGpr($sformatf("branch target %0d pre%0d", i, p), {16'h0000, target},
						regValCn1);
				end else
					checkCrId($sformatf("branch none %0d pre%0d", i, p), crZero, regIdCn1);
				checkAddr($sformatf("branch lr %0d pre%0d", i, p), call ? pc : lrIn, regOutLr);
			end
		end
		@(posedge clock);
		opPreBra <= 1'b0;
	endtask

	task automatic registerMoves();
		gpr_t r;
		gpr_t rs;
		gpr_t rt;
		gpr_t crm;
		gpr_t mask;
		imm_t imm;
		int sh;
		rs = randGpr();
		rt = randGpr();
		crm = randGpr();
		r = randGpr();
		imm = r[32:0];
		@(posedge clock);
		regValRs <= rs;
		regValRt <= rt;
		regValCRm <= crm;
		regValImm <= imm;
		regIdRm <= 6'h12;
		opUIxt <= 8'h00;
		opUCmd <= {condAlways, movCr};
		@(negedge clock);
		checkRegId("movCr id", 6'h12, regIdRn1);
		checkGpr("movCr value", crm, regValRn1);
		// control register id is the low five bits of Rm
		@(posedge clock);
		regIdRm <= 6'h2A;
		opUCmd <= {condAlways, movRc};
		@(negedge clock);
		checkCrId("movRc id", 5'h0A, regIdCn1);
		checkGpr("movRc value", rs, regValCn1);
		checkRegId("movRc gpr id", grZero, regIdRn1);
		for (int x = 1; x <= 5; x++) begin
			@(posedge clock);
			regIdRm <= 6'h12;
			opUIxt <= x[7:0];
			opUCmd <= {condAlways, movIr};
			@(negedge clock);
			if (x <= 3) begin
				// 8, 16 or 32 bits shifted in
				sh = 8 << (x - 1);
				mask = (64'd1 << sh) - 64'd1;
				checkGpr($sformatf("movIr ixt%0d", x), (rs << sh) | ({31'h0, imm} & mask),
					regValRn1);
			end else
				checkGpr($sformatf("movIr ixt%0d", x), rt, regValRn1);
		end
		for (int t = 0; t < 2; t++) begin
			@(posedge clock);
			regInSr <= {63'h0, t[0]};
			opUIxt <= {2'b00, ixsMovt};
			opUCmd <= {condAlways, opIxs};
			@(negedge clock);
			checkGpr($sformatf("movt t%0d", t), {63'h0, t[0]}, regValRn1);
			@(posedge clock);
			opUIxt <= {2'b00, ixsMovnt};
			@(negedge clock);
			checkGpr($sformatf("movnt t%0d", t), {63'h0, !t[0]}, regValRn1);
		end
	endtask

	task automatic statusAndTraps();
		gpr_t sr;
		gpr_t dlr;
		gpr_t expSr;
		for (int k = 0; k < 6; k++) begin
			sr = randGpr();
			expSr = sr;
			// T is bit 0 and S is bit 1
			case (srOps[k])
				ixtClrt: expSr[0] = 1'b0;
				ixtSett: expSr[0] = 1'b1;
				ixtClrs: expSr[1] = 1'b0;
				ixtSets: expSr[1] = 1'b1;
				ixtNott: expSr[0] = !sr[0];
				default: expSr[1] = !sr[1];
			endcase
			@(posedge clock);
			regInSr <= sr;
			opUIxt <= {2'b00, srOps[k]};
			opUCmd <= {condAlways, opIxt};
			@(negedge clock);
			checkGpr($sformatf("sr op %0d", k), expSr, regOutSr);
		end
		dlr = randGpr();
		@(posedge clock);
		regIdRm <= 6'h3B;
		regInDlr <= dlr;
		opUIxt <= {2'b00, ixtTrapa};
		@(negedge clock);
		checkTrap("trapa code", 16'hC08B, exTrapExc);
		@(posedge clock);
		opUIxt <= {2'b00, ixtSyse};
		@(negedge clock);
		checkTrap("syse code", {4'hE, dlr[11:0]}, exTrapExc);
		@(posedge clock);
		opUIxt <= {2'b00, ixtRte};
		@(negedge clock);
		checkTrap("rte code", 16'hFF00, exTrapExc);
	endtask

	task automatic stallCauses();
		int count;
		@(posedge clock);
		memDataOK <= 2'd0;
		regInExc <= '0;
		opUCmd <= {condAlways, 6'h3F};
		@(negedge clock);
		checkBit("unknown opcode hold", 1'b1, exHold);
		@(posedge clock);
		opUCmd <= {condAlways, invOp};
		@(negedge clock);
		checkBit("invOp hold", 1'b1, exHold);
		@(posedge clock);
		opUIxt <= {2'b00, ixtBreak};
		opUCmd <= {condAlways, opIxt};
		@(negedge clock);
		checkBit("break hold", 1'b1, exHold);
		// debugger bit lets the break through
		@(posedge clock);
		regInExc <= 64'h8000;
		@(negedge clock);
		checkBit("break passed", 1'b0, exHold);
		// port hold alone stalls nothing
		@(posedge clock);
		regInExc <= '0;
		opUIxt <= 8'h00;
		memDataOK <= memOkHold;
		opUCmd <= {condAlways, nop};
		@(negedge clock);
		checkBit("idle port hold", 1'b0, exHold);
		@(posedge clock);
		regIdRm <= 6'h0C;
		opUCmd <= {condAlways, movMr};
		@(negedge clock);
		checkBit("load port hold", 1'b1, exHold);
		// port releases three cycles later while the command stays put
		count = 0;
		while (exHold && (count < holdTimeout)) begin
			@(posedge clock);
			count++;
			if (count == 3)
				memDataOK <= 2'd0;
			@(negedge clock);
		end
		if (exHold) begin
			errors++;
			$display("timeout: exHold stayed high after the memory port released");
		end else if (count != 3) begin
			errors++;
			$display("error load hold cycles: expected 3, actual %0d", count);
		end
		for (int k = 0; k < 5; k++) begin
			@(posedge clock);
			regIdRm <= 6'h11;
			opUCmd <= {condAlways, longCmds[k]};
			@(negedge clock);
			checkBit($sformatf("long op %0d flag", k), 1'b1, regHeld);
			checkRegId($sformatf("long op %0d id", k), 6'h11, heldIdRn1);
			checkBit($sformatf("long op %0d hold", k), 1'b0, exHold);
		end
		@(posedge clock);
		opUCmd <= {condAlways, nop};
	endtask

	initial begin
		errors = 0;
		void'($urandom(32'h41ba63c9));
		initInputs();
		waitResetRelease();
		conditionGating();
		addressAndMemory();
		branchRedirect();
		registerMoves();
		statusAndTraps();
		stallCauses();
		@(negedge clock);
		$display("closing report, %0d errors counted", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* test/ex1Stage_chk.sv */
// concurrent checks on the EX1 top level, bound into every ex1Stage
// trap check excuses only the raw TRAPA, SYSE and RTE sub-op encodings
`timescale 1ns/1ps
`default_nettype none

module ex1StageChk (
	input logic clock,
	input logic reset,
	input logic [7:0] opUCmd,
	input ex1Pkg::ixt_t opUIxt,
	input ex1Pkg::regId_t heldIdRn1,
	input logic regHeld,
	input ex1Pkg::crId_t regIdCn1,
	input ex1Pkg::gpr_t regValCn1,
	input logic exHold,
	input ex1Pkg::trap_t exTrapExc
);
	import ex1Pkg::*;

	logic trapOp;

	// a trap sub-op on the command inputs
	assign trapOp = (opUCmd[5:0] == opIxt) && ((opUIxt[5:0] == ixtRte) ||
		(opUIxt[5:0] == ixtTrapa) || (opUIxt[5:0] == ixtSyse));

	// held flag tracks the held destination id
	heldFlag: assert property (@(posedge clock) disable iff (reset)
		regHeld == (heldIdRn1 != grZero))
		else $error("regHeld disagrees with heldIdRn1");

	// a PC write carries a 48-bit address only
	pcWidth: assert property (@(posedge clock) disable iff (reset)
		(regIdCn1 == crPc) |-> (regValCn1[63:48] == 16'h0000))
		else $error("PC write has nonzero upper bits");

	// no trap code without a trap sub-op or a stall
	trapQuiet: assert property (@(posedge clock) disable iff (reset)
		(!exHold && !trapOp) |-> (exTrapExc == '0))
		else $error("trap code raised without a trap sub-op");

endmodule

bind ex1Stage ex1StageChk uChk (
	.clock(clock),
	.reset(reset),
	.opUCmd(opUCmd),
	.opUIxt(opUIxt),
	.heldIdRn1(heldIdRn1),
	.regHeld(regHeld),
	.regIdCn1(regIdCn1),
	.regValCn1(regValCn1),
	.exHold(exHold),
	.exTrapExc(exTrapExc)
);

`default_nettype wire
